//--- compile.f
rtl/ex_pkg.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_branch.sv
rtl/ex_commit.sv
rtl/ex_top.sv
tests/tb_ex.sv

//--- rtl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; #(
    parameter int XLEN = 32
) (
    input  alu_op_e              alu_op_i,
    input  wire logic [XLEN-1:0] op1_i,
    input  wire logic [XLEN-1:0] op2_i,
    output logic      [XLEN-1:0] result_o
);

    localparam int SHAMT_W = shamt_w(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = op2_i[SHAMT_W-1:0]; // same slot for reg and imm forms
    assign lt_signed   = $signed(op1_i) < $signed(op2_i);
    assign lt_unsigned = op1_i < op2_i;

    always_comb begin
        case (alu_op_i)
            ADD: begin
                result_o = op1_i + op2_i;
            end
            SUB: begin
                result_o = op1_i - op2_i;
            end
            SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_signed};
            end
            SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            XOR: begin
                result_o = op1_i ^ op2_i;
            end
            OR: begin
                result_o = op1_i | op2_i;
            end
            AND: begin
                result_o = op1_i & op2_i;
            end
            SLL: begin
                result_o = op1_i << shamt;
            end
            SRL: begin
                result_o = op1_i >> shamt;
            end
            SRA: begin
                result_o = $unsigned($signed(op1_i) >>> shamt); // sign fill
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_branch.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch import ex_pkg::*; #(
    parameter int XLEN = 32
) (
    input  branch_cond_e         branch_cond_i,
    input  wire logic            is_jump_i,
    input  wire logic [XLEN-1:0] op1_i,
    input  wire logic [XLEN-1:0] op2_i,
    input  wire logic [XLEN-1:0] op1_jump_i,
    input  wire logic [XLEN-1:0] op2_jump_i,
    output logic                 take_jump_o,
    output logic      [XLEN-1:0] jump_target_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond_met;

    assign eq   = (op1_i == op2_i);
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (branch_cond_i)
            EQ:      cond_met = eq;
            NE:      cond_met = !eq;
            LT:      cond_met = lt_s;
            GE:      cond_met = !lt_s;
            LTU:     cond_met = lt_u;
            GEU:     cond_met = !lt_u;
            default: cond_met = 1'b0;
        endcase
    end

    assign take_jump_o   = is_jump_i | cond_met;
    assign jump_target_o = op1_jump_i + op2_jump_i; // masked later in commit

endmodule

`default_nettype wire

//--- rtl/ex_commit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_commit import ex_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic                  valid_i,
    input  wire logic                  reg_we_i,
    input  wire logic                  wb_allow_i,
    input  wire logic [REG_ADDR_W-1:0] reg_waddr_i,
    input  wire logic [XLEN-1:0]       alu_result_i,
    input  wire logic                  take_jump_i,
    input  wire logic [XLEN-1:0]       jump_target_i,
    output logic                       valid_o,
    output logic                       reg_we_o,
    output logic      [REG_ADDR_W-1:0] reg_waddr_o,
    output logic      [XLEN-1:0]       reg_wdata_o,
    output logic                       jump_flag_o,
    output logic      [XLEN-1:0]       jump_addr_o
);

    logic wr_en;
    logic jmp_en;

    assign wr_en  = valid_i & reg_we_i & wb_allow_i;
    assign jmp_en = valid_i & take_jump_i;

    // idle cycles leave everything at zero
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o     <= 1'b0;
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            reg_wdata_o <= '0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            valid_o     <= valid_i;
            reg_we_o    <= wr_en;
            reg_waddr_o <= wr_en ? reg_waddr_i : '0;
            reg_wdata_o <= wr_en ? alu_result_i : '0;
            jump_flag_o <= jmp_en;
            jump_addr_o <= jmp_en ? jump_target_i : '0;
        end
    end

    a_we_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_we_o |-> valid_o);

    a_jump_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        jump_flag_o |-> valid_o);

    // no stale target left on the bus
    a_addr_flag: assert property (@(posedge clk) disable iff (!rst_n_i)
        (jump_addr_o != '0) |-> jump_flag_o);

endmodule

`default_nettype wire

//--- rtl/ex_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ex_decode import ex_pkg::*; (
    input  wire logic [31:0]  inst_i,
    output alu_op_e           alu_op_o,
    output branch_cond_e      branch_cond_o,
    output logic              is_jump_o,
    output logic              wb_allow_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    alu_op_e    arith_op;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign alt    = inst_i[30];

    // addi has no sub form
    always_comb begin
        case (funct3)
            F3_ADD_SUB: arith_op = (alt && (opcode == OPC_OP)) ? SUB : ADD;
            F3_SLL:     arith_op = SLL;
            F3_SLT:     arith_op = SLT;
            F3_SLTU:    arith_op = SLTU;
            F3_XOR:     arith_op = XOR;
            F3_SRL_SRA: arith_op = alt ? SRA : SRL;
            F3_OR:      arith_op = OR;
            default:    arith_op = AND;
        endcase
    end

    always_comb begin
        alu_op_o      = ADD;
        branch_cond_o = NONE;
        is_jump_o     = 1'b0;
        wb_allow_o    = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                alu_op_o   = arith_op;
                wb_allow_o = 1'b1;
            end
            OPC_OP: begin
                alu_op_o   = arith_op;
                wb_allow_o = (funct7 == F7_BASE) || (funct7 == F7_ALT); // mul/div rejected
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  branch_cond_o = EQ;
                    F3_BNE:  branch_cond_o = NE;
                    F3_BLT:  branch_cond_o = LT;
                    F3_BGE:  branch_cond_o = GE;
                    F3_BLTU: branch_cond_o = LTU;
                    F3_BGEU: branch_cond_o = GEU;
                    default: branch_cond_o = NONE;
                endcase
            end
            OPC_JAL, OPC_JALR: begin
                is_jump_o  = 1'b1; // link value comes in on op1 + op2
                wb_allow_o = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                wb_allow_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int REG_ADDR_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA
    } alu_op_e;

    typedef enum logic [2:0] {
        NONE,
        EQ,
        NE,
        LT,
        GE,
        LTU,
        GEU
    } branch_cond_e;

    // shift amount width for a given data width
    function automatic int shamt_w(input int xlen);
        return $clog2(xlen);
    endfunction

endpackage

`default_nettype wire

//--- rtl/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top import ex_pkg::*; #(
    parameter int XLEN = 32
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,

    // from decode stage
    input  wire logic                  valid_i,
    input  wire logic [31:0]           inst_i,
    input  wire logic [XLEN-1:0]       op1_i,
    input  wire logic [XLEN-1:0]       op2_i,
    input  wire logic [XLEN-1:0]       op1_jump_i,
    input  wire logic [XLEN-1:0]       op2_jump_i,
    input  wire logic                  reg_we_i,
    input  wire logic [REG_ADDR_W-1:0] reg_waddr_i,

    // to memory stage
    output logic                       valid_o,
    output logic                       reg_we_o,
    output logic      [REG_ADDR_W-1:0] reg_waddr_o,
    output logic      [XLEN-1:0]       reg_wdata_o,
    output logic                       jump_flag_o,
    output logic      [XLEN-1:0]       jump_addr_o
);

    alu_op_e          alu_op;
    branch_cond_e     branch_cond;
    logic             is_jump;
    logic             wb_allow;
    logic [XLEN-1:0]  alu_result;
    logic             take_jump;
    logic [XLEN-1:0]  jump_target;

    ex_decode i_ex_decode (
        .inst_i        (inst_i),
        .alu_op_o      (alu_op),
        .branch_cond_o (branch_cond),
        .is_jump_o     (is_jump),
        .wb_allow_o    (wb_allow)
    );

    ex_alu #(.XLEN(XLEN)) i_ex_alu (
        .alu_op_i (alu_op),
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .result_o (alu_result)
    );

    ex_branch #(.XLEN(XLEN)) i_ex_branch (
        .branch_cond_i (branch_cond),
        .is_jump_i     (is_jump),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .op1_jump_i    (op1_jump_i),
        .op2_jump_i    (op2_jump_i),
        .take_jump_o   (take_jump),
        .jump_target_o (jump_target)
    );

    ex_commit #(.XLEN(XLEN)) i_ex_commit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .valid_i       (valid_i),
        .reg_we_i      (reg_we_i),
        .wb_allow_i    (wb_allow),
        .reg_waddr_i   (reg_waddr_i),
        .alu_result_i  (alu_result),
        .take_jump_i   (take_jump),
        .jump_target_i (jump_target),
        .valid_o       (valid_o),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .reg_wdata_o   (reg_wdata_o),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_ex

out=$(./obj_dir/Vtb_ex 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1

//--- tests/tb_ex.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex import ex_pkg::*; ();

    localparam int XLEN       = 32;
    localparam int CLK_PERIOD = 8;
    localparam int ALU_REPS   = 4;
    localparam int N_STREAM   = 10;
    localparam int GAP_SLOT   = 5;

    // clock cycles spent by each test
    localparam int RESET_CYCLES  = 4;
    localparam int ALU_CYCLES    = 10 * ALU_REPS * 2;
    localparam int BRANCH_CYCLES = 6 * 5 * 2;
    localparam int JUMP_CYCLES   = 4 * 2;
    localparam int STREAM_CYCLES = N_STREAM + 2;
    localparam int UNSUP_CYCLES  = 3 * 2;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + ALU_CYCLES + BRANCH_CYCLES
                                 + JUMP_CYCLES + STREAM_CYCLES + UNSUP_CYCLES;

    localparam logic [2:0] BR_F3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

    logic              clk;
    logic              rst_n;
    logic              valid;
    logic [31:0]       inst;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;
    logic [XLEN-1:0]   op1_jump;
    logic [XLEN-1:0]   op2_jump;
    logic              reg_we;
    logic [4:0]        reg_waddr;

    logic              out_valid;
    logic              out_we;
    logic [4:0]        out_waddr;
    logic [XLEN-1:0]   out_wdata;
    logic              out_jump;
    logic [XLEN-1:0]   out_jaddr;

    logic [15:0]       lfsr_state;

    ex_top #(.XLEN(XLEN)) i_ex_top (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .valid_i     (valid),
        .inst_i      (inst),
        .op1_i       (op1),
        .op2_i       (op2),
        .op1_jump_i  (op1_jump),
        .op2_jump_i  (op2_jump),
        .reg_we_i    (reg_we),
        .reg_waddr_i (reg_waddr),
        .valid_o     (out_valid),
        .reg_we_o    (out_we),
        .reg_waddr_o (out_waddr),
        .reg_wdata_o (out_wdata),
        .jump_flag_o (out_jump),
        .jump_addr_o (out_jaddr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // taps for x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", test, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31])
            return a[31]; // negative side is smaller
        return a < b;
    endfunction

    function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 32'd1;
            SLT:     return {31'd0, less_signed(a, b)};
            SLTU:    return {31'd0, a < b};
            XOR:     return a ^ b;
            OR:      return a | b;
            AND:     return a & b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | fill;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return less_signed(a, b);
            F3_BGE:  return !less_signed(a, b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] alu_inst(input alu_op_e op, input logic use_imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = F7_BASE;
        case (op)
            ADD:  f3 = F3_ADD_SUB;
            SUB: begin
                f3 = F3_ADD_SUB;
                f7 = F7_ALT;
            end
            SLT:  f3 = F3_SLT;
            SLTU: f3 = F3_SLTU;
            XOR:  f3 = F3_XOR;
            OR:   f3 = F3_OR;
            SLL:  f3 = F3_SLL;
            SRL:  f3 = F3_SRL_SRA;
            SRA: begin
                f3 = F3_SRL_SRA;
                f7 = F7_ALT;
            end
            default: f3 = F3_AND;
        endcase
        if (use_imm && op != SUB)
            return {f7, 5'd9, 5'd1, f3, 5'd3, OPC_OP_IMM}; // imm[11:5] carries funct7
        return {f7, 5'd2, 5'd1, f3, 5'd3, OPC_OP};
    endfunction

    // outputs sampled mid-cycle after the commit edge
    task automatic issue(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] ja, input logic [31:0] jb,
                         input logic we, input logic [4:0] wa);
        @(posedge clk);
        valid     <= 1'b1;
        inst      <= word;
        op1       <= a;
        op2       <= b;
        op1_jump  <= ja;
        op2_jump  <= jb;
        reg_we    <= we;
        reg_waddr <= wa;
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
    endtask

    task automatic expect_out(input string test, input logic we, input logic [4:0] wa,
                              input logic [31:0] wd, input logic jf, input logic [31:0] ja);
        check({test, " valid"}, 32'd1, 32'(out_valid));
        check({test, " we"}, 32'(we), 32'(out_we));
        check({test, " waddr"}, 32'(we ? wa : 5'd0), 32'(out_waddr));
        check({test, " wdata"}, we ? wd : 32'd0, out_wdata);
        check({test, " jump"}, 32'(jf), 32'(out_jump));
        check({test, " jaddr"}, jf ? ja : 32'd0, out_jaddr);
    endtask

    task automatic check_idle(input string test);
        check({test, " valid"}, 32'd0, 32'(out_valid));
        check({test, " we"}, 32'd0, 32'(out_we));
        check({test, " jump"}, 32'd0, 32'(out_jump));
    endtask

    task automatic reset_idle();
        for (int c = 0; c < 2; c++) begin
            @(posedge clk);
            @(negedge clk);
            check_idle("reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_idle("after reset");
    endtask

    task automatic alu_ops();
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        logic        we;
        logic [4:0]  wa;
        for (int i = 0; i < 10; i++) begin
            op = alu_op_e'(4'(i));
            for (int r = 0; r < ALU_REPS; r++) begin
                a  = rand_bits(32);
                b  = rand_bits(32);
                we = (r != 1); // one pass with the write disabled
                wa = 5'(rand_bits(5));
                issue(alu_inst(op, r[0]), a, b, 32'd0, 32'd0, we, wa);
                expect_out({"alu ", op.name()}, we, wa, alu_ref(op, a, b), 1'b0, 32'd0);
            end
        end
    endtask

    task automatic branch_conds();
        logic [31:0] x;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ja;
        logic [31:0] jb;
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 5; p++) begin
                x  = rand_bits(31);
                ja = rand_bits(32);
                jb = rand_bits(13);
                a  = x;
                b  = x;
                case (p)
                    1: b = x + 32'd1;
                    2: a = x + 32'd1;
                    3: a = x | 32'h8000_0000;
                    4: b = x | 32'h8000_0000;
                    default: ;
                endcase
                issue({7'd0, 5'd2, 5'd1, BR_F3[c], 5'd0, OPC_BRANCH}, a, b, ja, jb,
                      1'b1, 5'd7);
                expect_out($sformatf("branch f3=%0d pair %0d", BR_F3[c], p), 1'b0, 5'd0,
                           32'd0, branch_ref(BR_F3[c], a, b), ja + jb);
            end
        end
    endtask

    task automatic jumps_upper();
        logic [31:0] pc;
        logic [31:0] off;
        logic [31:0] base;
        pc   = rand_bits(30) << 2;
        off  = rand_bits(12);
        base = rand_bits(32);
        issue({20'h0, 5'd1, OPC_JAL}, pc, 32'd4, pc, off, 1'b1, 5'd1);
        expect_out("jal", 1'b1, 5'd1, pc + 32'd4, 1'b1, pc + off);
        issue({12'h0, 5'd5, 3'b000, 5'd1, OPC_JALR}, pc, 32'd4, base, off, 1'b1, 5'd1);
        expect_out("jalr", 1'b1, 5'd1, pc + 32'd4, 1'b1, base + off);
        issue({20'h12345, 5'd6, OPC_LUI}, 32'd0, 32'h1234_5000, pc, off, 1'b1, 5'd6);
        expect_out("lui", 1'b1, 5'd6, 32'h1234_5000, 1'b0, 32'd0);
        issue({20'habcde, 5'd7, OPC_AUIPC}, pc, 32'habcd_e000, pc, off, 1'b1, 5'd7);
        expect_out("auipc", 1'b1, 5'd7, pc + 32'habcd_e000, 1'b0, 32'd0);
    endtask

    task automatic back_to_back();
        logic [31:0] exp_wd [N_STREAM+1];
        logic [4:0]  exp_wa [N_STREAM+1];
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        for (int s = 0; s <= N_STREAM + 1; s++) begin
            @(posedge clk);
            if (s == GAP_SLOT || s > N_STREAM) begin
                valid <= 1'b0;
            end else begin
                op        = alu_op_e'(4'(rand_bits(4) % 10));
                a         = rand_bits(32);
                b         = rand_bits(32);
                exp_wd[s] = alu_ref(op, a, b);
                exp_wa[s] = 5'(s + 1);
                valid     <= 1'b1;
                inst      <= alu_inst(op, 1'b0);
                op1       <= a;
                op2       <= b;
                reg_we    <= 1'b1;
                reg_waddr <= exp_wa[s];
            end
            @(negedge clk);
            if (s > 0) begin
                if (s - 1 == GAP_SLOT)
                    check("stream gap valid", 32'd0, 32'(out_valid));
                else
                    expect_out($sformatf("stream slot %0d", s - 1), 1'b1, exp_wa[s-1],
                               exp_wd[s-1], 1'b0, 32'd0);
            end
        end
    endtask

    task automatic unsupported_ops();
        issue({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP}, rand_bits(32), rand_bits(32),
              32'h100, 32'h20, 1'b1, 5'd3);
        expect_out("mul", 1'b0, 5'd0, 32'd0, 1'b0, 32'd0);
        issue({12'h010, 5'd1, 3'b010, 5'd4, 7'b0000011}, rand_bits(32), 32'h10,
              32'h100, 32'h20, 1'b1, 5'd4);
        expect_out("load", 1'b0, 5'd0, 32'd0, 1'b0, 32'd0);
        issue({12'h300, 5'd1, 3'b001, 5'd5, 7'b1110011}, rand_bits(32), 32'd0,
              32'h100, 32'h20, 1'b1, 5'd5);
        expect_out("csr", 1'b0, 5'd0, 32'd0, 1'b0, 32'd0);
    endtask

    initial begin
        rst_n      = 1'b0;
        valid      = 1'b0;
        inst       = '0;
        op1        = '0;
        op2        = '0;
        op1_jump   = '0;
        op2_jump   = '0;
        reg_we     = 1'b0;
        reg_waddr  = '0;
        lfsr_state = 16'd14676;

        reset_idle();
        alu_ops();
        branch_conds();
        jumps_upper();
        back_to_back();
        unsupported_ops();

        @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
